// File: dataRam.sv
`timescale 1ns/1ps
`include "memStage_params.svh"

module dataRam import memStagePkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  dbusReq_t  dreq,
    output dbusResp_t dresp
);

    localparam int IdxBits = $clog2(`DATA_RAM_WORDS);
    localparam int CntBits = $clog2(`DATA_RAM_LATENCY + 1);

    word_t mem [`DATA_RAM_WORDS];

    logic               busyQ;
    logic [CntBits-1:0] cnt;
    logic [CntBits-1:0] nextCnt;
    logic               accept;
    logic               fire;
    logic               respOk;
    word_t              respData;
    logic [IdxBits-1:0] idx;

    assign idx = dreq.addr[3 +: IdxBits];              // Word index above the byte offset
    assign accept = dreq.valid & ~busyQ & ~respOk;

    // cnt counts the cycles the request has been visible so far
    assign nextCnt = busyQ ? cnt + 1'b1 : CntBits'(1);
    assign fire = (busyQ | accept) & (nextCnt == CntBits'(`DATA_RAM_LATENCY - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busyQ <= 1'b0;
            cnt <= '0;
            respOk <= 1'b0;
        end else begin
            respOk <= fire;                             // One-cycle pulse
            if (fire) begin
                busyQ <= 1'b0;
            end else if (busyQ | accept) begin
                busyQ <= 1'b1;
                cnt <= nextCnt;
            end
        end
    end

    // Request is held stable by the master until the response
    always_ff @(posedge clk) begin
        if (fire) begin
            for (int i = 0; i < 8; i++) begin
                if (dreq.strobe[i]) begin
                    mem[idx][8*i +: 8] <= dreq.data[8*i +: 8];
                end
            end
            respData <= mem[idx];
        end
    end

    assign dresp = '{addrOk: respOk, dataOk: respOk, data: respData};

endmodule

// File: loadExtract.sv
`timescale 1ns/1ps

module loadExtract import memStagePkg::*; (
    input  addr_t    addrReq,
    input  word_t    dataIn,
    input  memMode_t memMode,
    output word_t    data
);

    logic [2:0] offset;
    word_t      shifted;

    assign offset = addrReq[2:0];
    assign shifted = dataIn >> {offset, 3'b000};   // Addressed byte lands in bits 7:0

    always_comb begin
        case (memMode)
            modeLb: begin
                data = {{56{shifted[7]}}, shifted[7:0]};
            end
            modeLbu: begin
                data = {56'd0, shifted[7:0]};
            end
            modeLh: begin
                data = {{48{shifted[15]}}, shifted[15:0]};
            end
            modeLhu: begin
                data = {48'd0, shifted[15:0]};
            end
            modeLw: begin
                data = {{32{shifted[31]}}, shifted[31:0]};
            end
            modeLwu: begin
                data = {32'd0, shifted[31:0]};
            end
            modeLd: begin
                data = shifted;                        // Aligned, so offset is zero
            end
            default: begin
                data = dataIn;
            end
        endcase
    end

endmodule

// File: memAccess.sv
`timescale 1ns/1ps

module memAccess import memStagePkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  exMemReg_t   stageIn,
    output memWbReg_t   stageOut,
    output forwardSrc_t fwd,
    output dbusReq_t    dreq,
    input  dbusResp_t   dresp,
    output logic        okToProceed,
    input  logic        advance
);

    accState_t state;
    logic      newInstr;
    logic      isMemOp;
    logic      opDone;
    logic      issue;
    logic      respDone;
    word_t     loadData;

    addr_t     alignAddr;
    msize_t    alignSize;
    strobe_t   alignStrobe;
    word_t     alignData;
    word_t     extData;

    storeAlign storeAlign0 (
        .addrReq (stageIn.aluOut),
        .dataIn  (stageIn.rs2),
        .memMode (stageIn.memMode),
        .addr    (alignAddr),
        .size    (alignSize),
        .strobe  (alignStrobe),
        .data    (alignData)
    );

    loadExtract loadExtract0 (
        .addrReq (stageIn.aluOut),
        .dataIn  (dresp.data),
        .memMode (stageIn.memMode),
        .data    (extData)
    );

    assign isMemOp = stageIn.valid & (stageIn.isMemRead | stageIn.isMemWrite);
    assign opDone = (state == done);
    assign issue = (state == idle) & newInstr & isMemOp;
    assign respDone = (state == busy) & dresp.addrOk & dresp.dataOk;

    assign okToProceed = ~stageIn.valid | ~(stageIn.isMemRead | stageIn.isMemWrite) | opDone;

    // Forwarding source for the hazard unit
    assign fwd.valid = stageIn.valid & (stageIn.wd != '0);
    assign fwd.isWb = stageIn.isWriteBack;
    assign fwd.wd = stageIn.wd;
    assign fwd.wdData = stageIn.isMemRead ? loadData : stageIn.aluOut;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            newInstr <= 1'b1;
        end else begin
            newInstr <= advance;                       // Next cycle sees a fresh stageIn
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (issue) begin
                        state <= busy;
                    end
                end
                busy: begin
                    if (respDone) begin
                        state <= done;
                    end
                end
                default: begin
                    if (advance) begin
                        state <= idle;                 // Re-arm for the next instruction
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dreq <= '0;
        end else if (issue) begin
            dreq.valid <= 1'b1;
            dreq.addr <= alignAddr;
            dreq.size <= alignSize;
            dreq.strobe <= stageIn.isMemRead ? '0 : alignStrobe;
            dreq.data <= alignData;
        end else if (respDone) begin
            dreq.valid <= 1'b0;
        end
    end

    // Response is a single-cycle pulse, so hold on to the extracted value
    always_ff @(posedge clk) begin
        if (respDone) begin
            loadData <= extData;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stageOut <= '0;
        end else if (advance) begin
            stageOut.valid <= stageIn.valid;
            stageOut.isWriteBack <= stageIn.isWriteBack;
            stageOut.wd <= stageIn.wd;
            stageOut.aluOut <= stageIn.aluOut;
            stageOut.memOut <= stageIn.isMemRead ? loadData : '0;
            stageOut.isBranch <= stageIn.isBranch;
            stageOut.pcBranch <= stageIn.pcBranch;
            stageOut.instrAddr <= stageIn.instrAddr;
            stageOut.instr <= stageIn.instr;
        end
    end

endmodule

// File: memStagePkg.sv
`include "memStage_params.svh"

package memStagePkg;

    typedef logic [63:0] word_t;
    typedef logic [63:0] addr_t;
    typedef logic [7:0] strobe_t;
    typedef logic [`REG_IDX_BITS-1:0] regIdx_t;
    typedef logic [31:0] instr_t;

    typedef enum logic [2:0] {
        size1,
        size2,
        size4,
        size8
    } msize_t;

    typedef enum logic [3:0] {
        modeNone,
        modeLb,
        modeLh,
        modeLw,
        modeLd,
        modeLbu,
        modeLhu,
        modeLwu,
        modeSb,
        modeSh,
        modeSw,
        modeSd
    } memMode_t;

    typedef enum logic [1:0] {
        idle,
        busy,
        done
    } accState_t;

    typedef struct packed {
        logic valid;
        logic isMemRead;
        logic isMemWrite;
        logic isWriteBack;
        regIdx_t wd;
        word_t aluOut;           // Effective address for memory ops
        word_t rs2;              // Store data
        memMode_t memMode;
        logic isBranch;
        addr_t pcBranch;
        addr_t instrAddr;
        instr_t instr;
    } exMemReg_t;

    typedef struct packed {
        logic valid;
        logic isWriteBack;
        regIdx_t wd;
        word_t aluOut;
        word_t memOut;
        logic isBranch;
        addr_t pcBranch;
        addr_t instrAddr;
        instr_t instr;
    } memWbReg_t;

    typedef struct packed {
        logic valid;
        logic isWb;
        regIdx_t wd;
        word_t wdData;
    } forwardSrc_t;

    typedef struct packed {
        logic valid;
        addr_t addr;
        msize_t size;
        strobe_t strobe;         // All zero for a read
        word_t data;
    } dbusReq_t;

    typedef struct packed {
        logic addrOk;
        logic dataOk;
        word_t data;
    } dbusResp_t;

endpackage

// File: memStageTop.sv
`timescale 1ns/1ps

module memStageTop import memStagePkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  exMemReg_t   stageIn,
    output memWbReg_t   stageOut,
    output forwardSrc_t fwd,
    output logic        okToProceed,
    input  logic        advance
);

    dbusReq_t  dreq;
    dbusResp_t dresp;

    memAccess memAccess0 (
        .clk         (clk),
        .rst         (rst),
        .stageIn     (stageIn),
        .stageOut    (stageOut),
        .fwd         (fwd),
        .dreq        (dreq),
        .dresp       (dresp),
        .okToProceed (okToProceed),
        .advance     (advance)
    );

    dataRam dataRam0 (
        .clk   (clk),
        .rst   (rst),
        .dreq  (dreq),
        .dresp (dresp)
    );

endmodule

// File: memStage_params.svh
`ifndef MEM_STAGE_PARAMS_SVH
`define MEM_STAGE_PARAMS_SVH

// Data RAM geometry, counted in 64-bit words
`define DATA_RAM_WORDS 256

// Cycles a request stays outstanding on the data bus,
// the response pulse falls in the last of them
`define DATA_RAM_LATENCY 3

// Destination register index width
`define REG_IDX_BITS 5

`endif

// File: src.f
+incdir+.
memStagePkg.sv
storeAlign.sv
loadExtract.sv
memAccess.sv
dataRam.sv
memStageTop.sv
tbMemStage.sv

// File: storeAlign.sv
`timescale 1ns/1ps

module storeAlign import memStagePkg::*; (
    input  addr_t    addrReq,
    input  word_t    dataIn,
    input  memMode_t memMode,
    output addr_t    addr,
    output msize_t   size,
    output strobe_t  strobe,
    output word_t    data
);

    logic [2:0] offset;
    logic       isStore;
    strobe_t    laneMask;

    assign offset = addrReq[2:0];
    assign addr = addrReq;                     // Byte address goes out as is

    always_comb begin
        case (memMode)
            modeLb, modeLbu, modeSb: size = size1;
            modeLh, modeLhu, modeSh: size = size2;
            modeLw, modeLwu, modeSw: size = size4;
            default:                 size = size8;
        endcase
    end

    always_comb begin
        case (size)
            size1:   laneMask = 8'h01;
            size2:   laneMask = 8'h03;
            size4:   laneMask = 8'h0f;
            default: laneMask = 8'hff;
        endcase
    end

    always_comb begin
        case (memMode)
            modeSb, modeSh, modeSw, modeSd: isStore = 1'b1;
            default:                        isStore = 1'b0;
        endcase
    end

    // Move the low bytes of rs2 up to the addressed lane
    assign data = dataIn << {offset, 3'b000};
    assign strobe = isStore ? strobe_t'(laneMask << offset) : '0;

endmodule

// File: tbMemStage.sv
`timescale 1ns/1ps
`include "memStage_params.svh"

module tbMemStage import memStagePkg::*; ();

    localparam int ClkPeriod = 100;
    localparam int ShadowBytes = `DATA_RAM_WORDS * 8;
    localparam int InitWords = 16;                     // Test window in the data RAM
    localparam int StoreRounds = 6;
    localparam int LoadsPerMode = 4;
    localparam int NumInstr = InitWords + StoreRounds * 8 + LoadsPerMode * 7 + 4 + 2;
    localparam int MaxCycles = NumInstr * (`DATA_RAM_LATENCY + 8) + 100;

    logic        clk;
    logic        rst;
    exMemReg_t   stageIn;
    memWbReg_t   stageOut;
    forwardSrc_t fwd;
    logic        okToProceed;
    logic        advance;

    logic [7:0] shadow [ShadowBytes];
    memWbReg_t  expQ [$];

    memStageTop dut0 (
        .clk         (clk),
        .rst         (rst),
        .stageIn     (stageIn),
        .stageOut    (stageOut),
        .fwd         (fwd),
        .okToProceed (okToProceed),
        .advance     (advance)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    task automatic checkEq(string what, logic [319:0] got, logic [319:0] want);
        if (got !== want) begin
            $display("mismatch at %0t: %s got %0h expected %0h", $time, what, got, want);
            $display("Simulation FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic abortRun(string why);
        $display("error at %0t: %s", $time, why);
        $display("Simulation FAILED");
        $fatal(1, "run aborted");
    endtask

    function automatic int unsigned modeBytes(memMode_t m);
        case (m)
            modeLb, modeLbu, modeSb: return 1;
            modeLh, modeLhu, modeSh: return 2;
            modeLw, modeLwu, modeSw: return 4;
            default:                 return 8;
        endcase
    endfunction

    function automatic logic isLoad(memMode_t m);
        return (m >= modeLb) && (m <= modeLwu);
    endfunction

    // Expected load value built from the shadow bytes, little endian
    function automatic word_t loadRef(addr_t a, memMode_t m);
        word_t raw;
        raw = '0;
        for (int i = 0; i < modeBytes(m); i++) begin
            raw[8*i +: 8] = shadow[(a + i) % ShadowBytes];
        end
        case (m)
            modeLb:  return {{56{raw[7]}}, raw[7:0]};
            modeLh:  return {{48{raw[15]}}, raw[15:0]};
            modeLw:  return {{32{raw[31]}}, raw[31:0]};
            default: return raw;                       // Upper bytes already zero
        endcase
    endfunction

    function automatic exMemReg_t makeInstr(memMode_t m, addr_t a, word_t d, regIdx_t wd);
        exMemReg_t ins;
        ins = '0;
        ins.valid = 1'b1;
        ins.isMemRead = isLoad(m);
        ins.isMemWrite = (m != modeNone) && !isLoad(m);
        ins.isWriteBack = !ins.isMemWrite;
        ins.wd = wd;
        ins.aluOut = a;
        ins.rs2 = d;
        ins.memMode = m;
        ins.isBranch = (m == modeNone) ? 1'($urandom % 2) : 1'b0;
        ins.pcBranch = {$urandom, $urandom};
        ins.instrAddr = {$urandom, $urandom};
        ins.instr = $urandom;
        return ins;
    endfunction

    // Random address inside the test window, aligned to the access size
    function automatic addr_t randAddr(memMode_t m);
        int unsigned n;
        n = modeBytes(m);
        return addr_t'(($urandom % InitWords) * 8 + ($urandom % (8 / n)) * n);
    endfunction

    task automatic runInstr(exMemReg_t ins, int unsigned stall);
        memWbReg_t   want;
        memWbReg_t   held;
        word_t       fwdWant;
        int unsigned lowCycles;
        int unsigned wantLow;
        fwdWant = ins.isMemRead ? loadRef(ins.aluOut, ins.memMode) : ins.aluOut;
        want = '0;
        want.valid = ins.valid;
        want.isWriteBack = ins.isWriteBack;
        want.wd = ins.wd;
        want.aluOut = ins.aluOut;
        want.memOut = ins.isMemRead ? fwdWant : '0;
        want.isBranch = ins.isBranch;
        want.pcBranch = ins.pcBranch;
        want.instrAddr = ins.instrAddr;
        want.instr = ins.instr;
        wantLow = (ins.isMemRead || ins.isMemWrite) ? `DATA_RAM_LATENCY + 1 : 0;
        @(posedge clk);
        stageIn <= ins;
        advance <= 1'b0;
        expQ.push_back(want);
        if (ins.isMemWrite) begin
            for (int i = 0; i < modeBytes(ins.memMode); i++) begin
                shadow[(ins.aluOut + i) % ShadowBytes] = ins.rs2[8*i +: 8];
            end
        end
        lowCycles = 0;
        @(negedge clk);
        held = stageOut;
        while (okToProceed !== 1'b1) begin
            lowCycles++;
            checkEq("stageOut while waiting", stageOut, held);
            @(negedge clk);
        end
        checkEq("cycles with okToProceed low", lowCycles, wantLow);
        checkEq("fwd.valid", fwd.valid, ins.wd != '0);
        checkEq("fwd.isWb", fwd.isWb, ins.isWriteBack);
        checkEq("fwd.wd", fwd.wd, ins.wd);
        checkEq("fwd.wdData", fwd.wdData, fwdWant);
        repeat (stall) begin
            @(negedge clk);
            checkEq("okToProceed during stall", okToProceed, 1'b1);
            checkEq("second bus request during stall", dut0.dreq.valid, 1'b0);
            checkEq("stageOut during stall", stageOut, held);
        end
        @(posedge clk);
        advance <= 1'b1;                               // Latched on the next edge
    endtask

    // Every stageOut update is matched against the oldest expected record
    initial begin : compareOut
        memWbReg_t want;
        logic      latchedValid;
        forever begin
            @(posedge clk);
            if (!rst && advance) begin
                latchedValid = stageIn.valid;
                @(negedge clk);
                if (!latchedValid) begin
                    checkEq("bubble stageOut.valid", stageOut.valid, 1'b0);
                end else begin
                    want = expQ.pop_front();
                    checkEq("stageOut", stageOut, want);
                end
            end
        end
    end

    initial begin : watchdog
        #(MaxCycles * ClkPeriod);
        abortRun("watchdog expired before the test sequence finished");
    end

    initial begin : mainSeq
        addr_t    a;
        memMode_t m;
        void'($urandom(32'hd154aed8));
        rst = 1'b1;
        advance = 1'b0;
        stageIn = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkEq("stageOut.valid after reset", stageOut.valid, 1'b0);
        checkEq("okToProceed with no instruction", okToProceed, 1'b1);
        @(posedge clk);
        advance <= 1'b1;

        // RAM is not reset, so fill the window first
        for (int w = 0; w < InitWords; w++) begin
            runInstr(makeInstr(modeSd, addr_t'(w * 8), {$urandom, $urandom}, '0), 0);
        end

        for (int r = 0; r < StoreRounds; r++) begin
            for (int s = 0; s < 4; s++) begin
                m = memMode_t'(modeSb + s);
                a = randAddr(m);
                runInstr(makeInstr(m, a, {$urandom, $urandom}, regIdx_t'($urandom)),
                         $urandom % 4);
                runInstr(makeInstr(modeLd, {a[63:3], 3'b000}, '0, regIdx_t'($urandom)),
                         $urandom % 4);
            end
        end

        for (int s = 0; s < 7; s++) begin
            m = memMode_t'(modeLb + s);
            repeat (LoadsPerMode) begin
                runInstr(makeInstr(m, randAddr(m), '0, regIdx_t'($urandom)), $urandom % 4);
            end
        end

        // Two with wd zero, two with a real destination
        for (int k = 0; k < 4; k++) begin
            runInstr(makeInstr(modeNone, {$urandom, $urandom}, {$urandom, $urandom},
                               (k < 2) ? regIdx_t'(0) : regIdx_t'($urandom | 1)), 0);
        end

        a = randAddr(modeSw);
        runInstr(makeInstr(modeSw, a, {$urandom, $urandom}, '0), 4 + $urandom % 4);
        runInstr(makeInstr(modeLw, a, '0, regIdx_t'($urandom | 1)), 4 + $urandom % 4);

        @(posedge clk);
        stageIn <= '0;
        repeat (3) @(negedge clk);
        checkEq("expected records left over", expQ.size(), 0);
        $display("Simulation PASSED");
        $finish;
    end

endmodule
